// File: gfx_vram.f
verilog/gfx_mem_pkg.sv
verilog/gfx_bank_decode.sv
verilog/gfx_bank_grant.sv
verilog/gfx_read_return.sv
verilog/gfx_memory_arbiter.sv
verilog/gfx_bank_ram.sv
verilog/gfx_vram.sv
verification/gfx_vram_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the gfx_vram testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module gfx_vram_tb -f gfx_vram.f

# the log decides the result, so a non-zero exit here must not stop the script
./obj_dir/Vgfx_vram_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

// File: verification/gfx_vram_tb.sv
module gfx_vram_tb import gfx_mem_pkg::*; ();

	localparam int PERIOD       = 40;
	localparam int LATENCY      = 2; // DUT default BANK_LATENCY
	localparam int READ_TIMEOUT = 200;
	localparam int NUM_WRITES   = 256;
	localparam int RANDOM_CYCLES = 500;

	logic          CLK;
	logic          RSTb;
	gfx_read_req_t req [NUM_CLIENTS];
	gfx_read_rsp_t rsp [NUM_CLIENTS];
	gfx_write_t    cpu_wr;

	logic [15:0] shadow [0:65535]; // mirror of every cpu write
	logic [15:0] written [NUM_WRITES];
	logic [31:0] rng_state = 32'd56;
	int          last_wait [NUM_CLIENTS]; // edges with rready low
	time         done_at [NUM_CLIENTS];
	int          words_checked = 0;

	gfx_vram gfx_vram_inst (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.sprite_req (req[CL_SPRITE]),
		.bg0_req    (req[CL_BG0]),
		.bg1_req    (req[CL_BG1]),
		.ov_req     (req[CL_OV]),
		.sprite_rsp (rsp[CL_SPRITE]),
		.bg0_rsp    (rsp[CL_BG0]),
		.bg1_rsp    (rsp[CL_BG1]),
		.ov_rsp     (rsp[CL_OV]),
		.cpu_wr     (cpu_wr)
	);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// byte-swapped address so every word of the 64K differs
	function automatic logic [15:0] fill_word(input logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'h5a3c;
	endfunction

	function automatic logic [15:0] expected_word(input logic [15:0] a);
		return shadow[a];
	endfunction

	function automatic string client_name(input int c);
		case (c)
			0: return "sprite";
			1: return "bg0";
			2: return "bg1";
			default: return "overlay";
		endcase
	endfunction

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at time %0t: %s (got %0h, expected %0h)",
				$time, what, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_idle_outputs(input string when);
		for (int c = 0; c < NUM_CLIENTS; c++) begin
			check_equal(32'(rsp[c]), 32'd0,
				$sformatf("%s response not idle %s", client_name(c), when));
		end
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [15:0] data);
		@(negedge CLK);
		cpu_wr.en    = 1'b1;
		cpu_wr.addr  = addr;
		cpu_wr.data  = data;
		shadow[addr] = data;
	endtask

	// hold keeps rvalid up for the next burst word
	task automatic client_read(input int c, input logic [15:0] addr, input bit hold);
		int n;
		n = 0;
		@(negedge CLK);
		req[c].addr   = addr;
		req[c].rvalid = 1'b1;
		@(posedge CLK);
		while (rsp[c].rready !== 1'b1) begin
			n++;
			if (n >= READ_TIMEOUT) begin
				$display("read timeout: %s client got no rready for address %04h in %0d cycles",
					client_name(c), addr, n);
				$display("TEST FAIL");
				$fatal(1, "client stalled");
			end
			@(posedge CLK);
		end
		last_wait[c] = n;
		done_at[c]   = $time;
		if (!hold) begin
			@(negedge CLK);
			req[c].rvalid = 1'b0;
		end
	endtask

	task automatic random_traffic(input int c, input time stop_at);
		logic [31:0] r;
		logic [15:0] addr;
		int          gap;
		int          extra;
		while ($time < stop_at) begin
			r     = next_rand();
			gap   = int'(r[1:0]);
			extra = (r[3:2] == 2'b11) ? 3 : 0; // sometimes a short burst
			addr  = r[31:16];
			repeat (gap) @(negedge CLK);
			for (int k = 0; k <= extra; k++) begin
				client_read(c, {addr[15:14], addr[13:0] + 14'(k)}, k < extra);
			end
		end
	endtask

	// compares every word the DUT hands back
	always @(posedge CLK) begin
		for (int c = 0; c < NUM_CLIENTS; c++) begin
			if (rsp[c].rready === 1'b1) begin
				check_equal(32'(rsp[c].data), 32'(expected_word(req[c].addr)),
					$sformatf("%s data at address %04h", client_name(c), req[c].addr));
				words_checked++;
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [15:0] a;
		time         stop_at;
		int          seen_before;

		RSTb   = 1'b0;
		cpu_wr = '0;
		for (int c = 0; c < NUM_CLIENTS; c++) begin
			req[c] = '0;
		end

		repeat (10) begin
			@(negedge CLK);
			check_idle_outputs("during reset");
		end
		RSTb = 1'b1;
		repeat (3) begin
			@(negedge CLK);
			check_idle_outputs("after reset");
		end

		for (int i = 0; i < 65536; i++) begin
			cpu_write(16'(i), fill_word(16'(i)));
		end
		for (int i = 0; i < NUM_WRITES; i++) begin
			r          = next_rand();
			written[i] = r[15:0];
			cpu_write(r[15:0], r[31:16]);
		end
		@(negedge CLK);
		cpu_wr.en = 1'b0;

		// single client alone in every bank plus some written words
		for (int c = 0; c < NUM_CLIENTS; c++) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				r = next_rand();
				client_read(c, {2'(b), r[13:0]}, 1'b0);
				check_equal(32'(last_wait[c] >= LATENCY && last_wait[c] <= LATENCY + 1), 32'd1,
					$sformatf("%s uncontended latency %0d", client_name(c), last_wait[c]));
			end
			for (int k = 0; k < 4; k++) begin
				r = next_rand();
				client_read(c, written[r[7:0]], 1'b0);
			end
		end

		// all four on one bank
		r = next_rand();
		a = {2'b01, r[13:2], 2'b00};
		fork
			client_read(CL_SPRITE, a, 1'b0);
			client_read(CL_BG0, a + 16'd1, 1'b0);
			client_read(CL_BG1, a + 16'd2, 1'b0);
			client_read(CL_OV, a + 16'd3, 1'b0);
		join
		for (int c = 1; c < NUM_CLIENTS; c++) begin
			check_equal(32'(done_at[c] >= done_at[c-1] + 64'((LATENCY + 1) * PERIOD)), 32'd1,
				$sformatf("%s served too early after %s", client_name(c), client_name(c - 1)));
		end

		// one bank each with no interference
		r = next_rand();
		fork
			client_read(CL_SPRITE, {2'd1, r[13:0]}, 1'b0);
			client_read(CL_BG0, {2'd2, r[13:0]}, 1'b0);
			client_read(CL_BG1, {2'd3, r[13:0]}, 1'b0);
			client_read(CL_OV, {2'd0, r[13:0]}, 1'b0);
		join
		for (int c = 0; c < NUM_CLIENTS; c++) begin
			check_equal(32'(last_wait[c] <= LATENCY + 1), 32'd1,
				$sformatf("%s waited %0d cycles on its own bank", client_name(c), last_wait[c]));
		end

		// bg0 burst of eight with sprite blocked on the same bank
		r = next_rand();
		a = {2'b10, r[13:4], 4'h0};
		fork
			begin
				for (int k = 0; k < 8; k++) begin
					client_read(CL_BG0, a + 16'(k), k < 7);
				end
			end
			begin
				repeat (2) @(negedge CLK);
				client_read(CL_SPRITE, a + 16'd12, 1'b0);
			end
		join
		check_equal(32'(done_at[CL_SPRITE] > done_at[CL_BG0]), 32'd1,
			"sprite got the bank during the bg0 burst");

		seen_before = words_checked;
		stop_at     = $time + time'(RANDOM_CYCLES * PERIOD);
		fork
			random_traffic(CL_SPRITE, stop_at);
			random_traffic(CL_BG0, stop_at);
			random_traffic(CL_BG1, stop_at);
			random_traffic(CL_OV, stop_at);
		join
		check_equal(32'(words_checked > seen_before + 40), 32'd1,
			"too few words returned under random traffic");

		repeat (4) @(negedge CLK);
		$display("TEST PASS");
		$finish;
	end

endmodule

// File: verilog/gfx_bank_decode.sv
module gfx_bank_decode import gfx_mem_pkg::*; (
	input  gfx_read_req_t [NUM_CLIENTS-1:0] client_req,
	input  gfx_grant_t    [NUM_BANKS-1:0]   grant,
	output gfx_pick_t     [NUM_BANKS-1:0]   bank_pick
);

	// held[b][c]: client c owns some bank other than b
	logic [NUM_BANKS-1:0][NUM_CLIENTS-1:0] held;

	always_comb begin
		held = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int c = 0; c < NUM_CLIENTS; c++) begin
				for (int ob = 0; ob < NUM_BANKS; ob++) begin
					if (ob != b && grant[ob].active && grant[ob].client == 2'(c)) begin
						held[b][c] = 1'b1;
					end
				end
			end
		end
	end

	// walk from lowest priority up so the highest requester wins
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			bank_pick[b] = '0;
			for (int c = NUM_CLIENTS - 1; c >= 0; c--) begin
				if (client_req[c].rvalid &&
					client_req[c].addr[15:14] == 2'(b) &&
					!held[b][c]) begin
					bank_pick[b].valid  = 1'b1;
					bank_pick[b].client = gfx_client_e'(2'(c));
				end
			end
		end
	end

endmodule

// File: verilog/gfx_bank_grant.sv
module gfx_bank_grant import gfx_mem_pkg::*; (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  gfx_pick_t                       pick,
	input  gfx_read_req_t [NUM_CLIENTS-1:0] client_req,
	output gfx_bank_req_t                   bank_req,
	output gfx_grant_t                      grant
);

	gfx_grant_state_e state;
	gfx_grant_state_e state_next;
	gfx_client_e      owner;
	gfx_client_e      owner_next;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= GS_IDLE;
			owner <= CL_SPRITE;
		end else begin
			state <= state_next;
			owner <= owner_next;
		end
	end

	always_comb begin
		state_next = state;
		owner_next = owner;
		bank_req   = '0;
		case (state)
			GS_IDLE: begin
				if (pick.valid) begin
					// claim now, bank sees the address this cycle
					bank_req.addr  = client_req[pick.client].addr[13:0];
					bank_req.valid = 1'b1;
					state_next     = GS_OWNED;
					owner_next     = pick.client;
				end
			end
			GS_OWNED: begin
				bank_req.addr  = client_req[owner].addr[13:0]; // follows bursts
				bank_req.valid = client_req[owner].rvalid;
				if (!client_req[owner].rvalid) begin
					state_next = GS_IDLE; // owner let go
				end
			end
			default: begin
				state_next = GS_IDLE;
			end
		endcase
	end

	assign grant.active = (state == GS_OWNED);
	assign grant.client = owner;

endmodule

// File: verilog/gfx_bank_ram.sv
module gfx_bank_ram import gfx_mem_pkg::*; #(
	parameter int BANK_LATENCY = 2
) (
	input  logic          CLK,
	input  logic          RSTb,
	input  gfx_bank_req_t bank_req,
	output gfx_bank_rsp_t bank_rsp,
	input  logic          wr_en,
	input  logic [13:0]   wr_addr,
	input  logic [15:0]   wr_data
);

	localparam int CNT_W = $clog2(BANK_LATENCY + 1);

	logic [15:0]      mem [0:16383];
	logic [15:0]      dout_r;
	logic [13:0]      last_addr;
	logic [CNT_W-1:0] count; // cycles the current address has been stable
	logic             same_addr;

	assign same_addr = (count != '0) && (bank_req.addr == last_addr);

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge CLK) begin
		dout_r    <= mem[bank_req.addr];
		last_addr <= bank_req.addr;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			count <= '0;
		end else if (!bank_req.valid) begin
			count <= '0;
		end else if (!same_addr) begin
			count <= CNT_W'(1); // new address, restart
		end else if (count < CNT_W'(BANK_LATENCY)) begin
			count <= count + CNT_W'(1);
		end
	end

	// drops at once when the address moves on
	assign bank_rsp.ready = bank_req.valid && same_addr && (count >= CNT_W'(BANK_LATENCY));
	assign bank_rsp.dout  = dout_r;

endmodule

// File: verilog/gfx_mem_pkg.sv
package gfx_mem_pkg;

	localparam int NUM_CLIENTS = 4; // fixed by the priority order
	localparam int NUM_BANKS   = 4; // addr[15:14]

	// index order is priority order, sprite highest
	typedef enum logic [1:0] {
		CL_SPRITE = 2'd0,
		CL_BG0    = 2'd1,
		CL_BG1    = 2'd2,
		CL_OV     = 2'd3
	} gfx_client_e;

	typedef enum logic {
		GS_IDLE  = 1'b0,
		GS_OWNED = 1'b1
	} gfx_grant_state_e;

	typedef struct packed {
		logic [15:0] addr;
		logic        rvalid; // address valid, held until rready
	} gfx_read_req_t;

	typedef struct packed {
		logic [15:0] data;
		logic        rready; // data valid for current address
	} gfx_read_rsp_t;

	typedef struct packed {
		logic [13:0] addr;
		logic        valid;
	} gfx_bank_req_t;

	typedef struct packed {
		logic [15:0] dout;
		logic        ready;
	} gfx_bank_rsp_t;

	typedef struct packed {
		logic        valid;
		gfx_client_e client;
	} gfx_pick_t;

	typedef struct packed {
		logic        active;
		gfx_client_e client;
	} gfx_grant_t;

	typedef struct packed {
		logic        en;
		logic [15:0] addr;
		logic [15:0] data;
	} gfx_write_t;

endpackage

// File: verilog/gfx_memory_arbiter.sv
module gfx_memory_arbiter import gfx_mem_pkg::*; (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  gfx_read_req_t [NUM_CLIENTS-1:0] client_req,
	output gfx_read_rsp_t [NUM_CLIENTS-1:0] client_rsp,
	output gfx_bank_req_t [NUM_BANKS-1:0]   bank_req,
	input  gfx_bank_rsp_t [NUM_BANKS-1:0]   bank_rsp
);

	gfx_pick_t  [NUM_BANKS-1:0] bank_pick;
	gfx_grant_t [NUM_BANKS-1:0] grant;

	gfx_bank_decode gfx_bank_decode_inst (
		.client_req (client_req),
		.grant      (grant),
		.bank_pick  (bank_pick)
	);

	// one independent grant unit per bank
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		gfx_bank_grant gfx_bank_grant_inst (
			.CLK        (CLK),
			.RSTb       (RSTb),
			.pick       (bank_pick[b]),
			.client_req (client_req),
			.bank_req   (bank_req[b]),
			.grant      (grant[b])
		);
	end

	gfx_read_return gfx_read_return_inst (
		.grant      (grant),
		.bank_rsp   (bank_rsp),
		.client_rsp (client_rsp)
	);

endmodule

// File: verilog/gfx_read_return.sv
module gfx_read_return import gfx_mem_pkg::*; (
	input  gfx_grant_t    [NUM_BANKS-1:0]   grant,
	input  gfx_bank_rsp_t [NUM_BANKS-1:0]   bank_rsp,
	output gfx_read_rsp_t [NUM_CLIENTS-1:0] client_rsp
);

	// a client owns at most one bank at a time
	always_comb begin
		for (int c = 0; c < NUM_CLIENTS; c++) begin
			client_rsp[c] = '0;
			for (int b = 0; b < NUM_BANKS; b++) begin
				if (grant[b].active && grant[b].client == 2'(c)) begin
					client_rsp[c].data   = bank_rsp[b].dout;
					client_rsp[c].rready = bank_rsp[b].ready;
				end
			end
		end
	end

endmodule

// File: verilog/gfx_vram.sv
module gfx_vram import gfx_mem_pkg::*; #(
	parameter int BANK_LATENCY = 2
) (
	input  logic          CLK,
	input  logic          RSTb,
	input  gfx_read_req_t sprite_req,
	input  gfx_read_req_t bg0_req,
	input  gfx_read_req_t bg1_req,
	input  gfx_read_req_t ov_req,
	output gfx_read_rsp_t sprite_rsp,
	output gfx_read_rsp_t bg0_rsp,
	output gfx_read_rsp_t bg1_rsp,
	output gfx_read_rsp_t ov_rsp,
	input  gfx_write_t    cpu_wr
);

	gfx_read_req_t [NUM_CLIENTS-1:0] client_req;
	gfx_read_rsp_t [NUM_CLIENTS-1:0] client_rsp;
	gfx_bank_req_t [NUM_BANKS-1:0]   bank_req;
	gfx_bank_rsp_t [NUM_BANKS-1:0]   bank_rsp;

	assign client_req[CL_SPRITE] = sprite_req;
	assign client_req[CL_BG0]    = bg0_req;
	assign client_req[CL_BG1]    = bg1_req;
	assign client_req[CL_OV]     = ov_req;

	assign sprite_rsp = client_rsp[CL_SPRITE];
	assign bg0_rsp    = client_rsp[CL_BG0];
	assign bg1_rsp    = client_rsp[CL_BG1];
	assign ov_rsp     = client_rsp[CL_OV];

	gfx_memory_arbiter gfx_memory_arbiter_inst (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.client_req (client_req),
		.client_rsp (client_rsp),
		.bank_req   (bank_req),
		.bank_rsp   (bank_rsp)
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		logic wr_en;

		// cpu writes go straight in, no arbitration
		assign wr_en = cpu_wr.en && (cpu_wr.addr[15:14] == 2'(b));

		gfx_bank_ram #(
			.BANK_LATENCY (BANK_LATENCY)
		) gfx_bank_ram_inst (
			.CLK      (CLK),
			.RSTb     (RSTb),
			.bank_req (bank_req[b]),
			.bank_rsp (bank_rsp[b]),
			.wr_en    (wr_en),
			.wr_addr  (cpu_wr.addr[13:0]),
			.wr_data  (cpu_wr.data)
		);
	end

endmodule
